// File: sim.f
+incdir+include
verilog/ifu_types_pkg.sv
verilog/ifu_bus_pkg.sv
verilog/ifu_fetch_ctrl.sv
verilog/ifu_pc_gen.sv
verilog/ifu_minidec.sv
verilog/ifu_ifu2itcm.sv
verilog/ifu_ir_stage.sv
verilog/ifu.sv
tests/ifu_clock_gen.sv
tests/ifu_properties.sv
tests/ifu_tb.sv

// File: tests/ifu_tb.sv
/* testbench for the fetch unit: ITCM model with random latency, a short
   program with branches and a JAL, expected-stream check on each handoff */
`timescale 1ns/1ns
`include "ifu_consts.svh"

module ifu_tb;
  import ifu_types_pkg::*;
  import ifu_bus_pkg::*;

  localparam int  DEPTH      = 1 << `IFU_ITCM_ADDR_WIDTH;
  // 140 handoffs at up to ~8 cycles each, plus reset, flush and halt, with wide margin
  localparam int  MAX_CYCLES = 4000;
  localparam int  EXP_DEPTH  = 200;
  localparam pc_t RTVEC      = 32'h0000_0100;

  logic       clk;
  logic       reset;
  pc_t        pc_rtvec;
  pc_t        inspect_pc;
  logic       itcm_cmd_valid;
  logic       itcm_cmd_ready;
  itcm_addr_t itcm_cmd_addr;
  logic       itcm_rsp_valid = 1'b0;
  logic       itcm_rsp_ready;
  instr_t     itcm_rsp_rdata = '0;
  logic       ifu_o_valid;
  logic       ifu_o_ready = 1'b0;
  ir_stage_t  ifu_o;
  logic       flush_req;
  flush_t     flush;
  logic       flush_ack;
  logic       halt_req;
  logic       halt_ack;

  // program image and the prediction each word should get
  instr_t     mem [DEPTH];
  logic       taken_mem [DEPTH];
  pc_t        off_mem [DEPTH];
  ir_stage_t  exp_q [$];

  // ITCM model
  logic       rsp_pend;
  int         rsp_wait;
  itcm_addr_t rsp_addr;
  logic       first_cmd_seen = 1'b0;
  logic       stall_on;

  string      test_name;
  int         cycles;
  int         errors;
  int         checks;
  int         handoffs;
  int         taken_seen;
  int         stalls;
  int         err_at_start;
  int         tests_run;
  int         tests_failed;

  ifu_clock_gen ifu_clock_gen_inst (
    .clk (clk)
  );

  ifu ifu_inst (
    .clk            (clk),
    .reset          (reset),
    .pc_rtvec       (pc_rtvec),
    .inspect_pc     (inspect_pc),
    .itcm_cmd_valid (itcm_cmd_valid),
    .itcm_cmd_ready (itcm_cmd_ready),
    .itcm_cmd_addr  (itcm_cmd_addr),
    .itcm_rsp_valid (itcm_rsp_valid),
    .itcm_rsp_ready (itcm_rsp_ready),
    .itcm_rsp_rdata (itcm_rsp_rdata),
    .ifu_o_valid    (ifu_o_valid),
    .ifu_o_ready    (ifu_o_ready),
    .ifu_o          (ifu_o),
    .flush_req      (flush_req),
    .flush          (flush),
    .flush_ack      (flush_ack),
    .halt_req       (halt_req),
    .halt_ack       (halt_ack)
  );

  bind ifu ifu_properties ifu_properties_inst (.*);

  // ====================================================================
  // program builder and expected stream
  // ====================================================================
  function automatic instr_t jal_word(rfidx_t rd, pc_t off);
    return {off[20], off[10:1], off[11], off[19:12], rd, `IFU_OPC_JAL};
  endfunction

  function automatic instr_t branch_word(logic [2:0] f3, rfidx_t rs1, rfidx_t rs2, pc_t off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `IFU_OPC_BRANCH};
  endfunction

  // JAL always taken, branch taken only on a negative offset
  task automatic place(pc_t at, instr_t word, pc_t off, logic is_jal);
    mem[at[15:2]]       = word;
    off_mem[at[15:2]]   = off;
    taken_mem[at[15:2]] = is_jal || off[31];
  endtask

  task automatic build_program();
    itcm_addr_t a;
    for (int i = 0; i < DEPTH; i++) begin
      a = itcm_addr_t'(i);
      // addi with every field taken from the word address
      mem[i]       = {a[11:0], a[6:2], 3'b000, a[13:12], a[2:0], 7'b0010011};
      off_mem[i]   = '0;
      taken_mem[i] = 1'b0;
    end
    // loop 0x110..0x13c: forward beq, JAL over a gap, backward bne
    place(32'h110, branch_word(3'b000, 5'd3, 5'd4, 32'd8), 32'd8, 1'b0);
    place(32'h118, jal_word(5'd1, 32'h18), 32'h18, 1'b1);
    place(32'h13c, branch_word(3'b001, 5'd5, 5'd6, -32'sd44), -32'sd44, 1'b0);
  endtask

  function automatic ir_stage_t expected_at(pc_t pc);
    ir_stage_t e;
    e.ir         = mem[pc[15:2]];
    e.pc         = pc;
    e.rs1idx     = e.ir[19:15];
    e.rs2idx     = e.ir[24:20];
    e.prdt_taken = taken_mem[pc[15:2]];
    return e;
  endfunction

  // walk the program from start, following the prediction
  task automatic refill_expected(pc_t start);
    pc_t pc;
    exp_q.delete();
    pc = start;
    repeat (EXP_DEPTH) begin
      exp_q.push_back(expected_at(pc));
      pc = taken_mem[pc[15:2]] ? pc + off_mem[pc[15:2]] : pc + 32'd4;
    end
  endtask

  function automatic int error_total();
    return errors + ifu_inst.ifu_properties_inst.failures;
  endfunction

  task automatic start_test(string name);
    test_name    = name;
    err_at_start = error_total();
  endtask

  task automatic end_test();
    int n;
    n = error_total() - err_at_start;
    tests_run++;
    if (n == 0) begin
      $display("test %-12s passed", test_name);
    end else begin
      tests_failed++;
      $display("test %-12s failed with %0d errors", test_name, n);
    end
  endtask

  task automatic run_handoffs(int n);
    int target;
    target = handoffs + n;
    while (handoffs < target) @(posedge clk);
  endtask

  // hold flush_req until the ack is seen
  task automatic redirect(pc_t op1, pc_t op2);
    repeat ($urandom_range(3, 0)) @(posedge clk);
    flush_req <= 1'b1;
    flush     <= '{add_op1: op1, add_op2: op2};
    do begin
      @(posedge clk);
    end while (!flush_ack);
    flush_req <= 1'b0;
  endtask

  // ====================================================================
  // ITCM model, execute side and checking
  // ====================================================================
  always @(posedge clk) begin
    if (reset) begin
      itcm_rsp_valid <= 1'b0;
      rsp_pend = 1'b0;
      rsp_wait = 0;
    end else begin
      if (itcm_rsp_valid && itcm_rsp_ready) begin
        itcm_rsp_valid <= 1'b0;
      end
      if (itcm_cmd_valid && itcm_cmd_ready) begin
        if (!first_cmd_seen) begin
          first_cmd_seen = 1'b1;
          checks++;
          assert (itcm_cmd_addr == pc_rtvec[15:2])
            else begin
              errors++;
              $display("** Error %s: expected %h actual %h", test_name, pc_rtvec[15:2],
                       itcm_cmd_addr);
            end
        end
        rsp_addr = itcm_cmd_addr;
        rsp_wait = $urandom_range(3, 0);
        rsp_pend = 1'b1;
      end
      // latency 0 answers in the cycle right after the command
      if (rsp_pend) begin
        if (rsp_wait == 0) begin
          itcm_rsp_valid <= 1'b1;
          itcm_rsp_rdata <= mem[rsp_addr];
          rsp_pend = 1'b0;
        end else begin
          rsp_wait--;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (stall_on) begin
      // execute busy about one cycle in four
      ifu_o_ready <= ($urandom_range(3, 0) != 0);
    end else begin
      ifu_o_ready <= 1'b1;
    end
  end

  always @(posedge clk) begin
    ir_stage_t want;
    if (reset) begin
      refill_expected(pc_rtvec);
    end else begin
      if (ifu_o_valid && ifu_o_ready) begin
        handoffs++;
        if (ifu_o.prdt_taken) begin
          taken_seen++;
        end
        if (exp_q.size() == 0) begin
          errors++;
          $display("%s: handoff at pc %h with no expected entry left", test_name, ifu_o.pc);
        end else begin
          want = exp_q.pop_front();
          checks++;
          assert (ifu_o == want)
            else begin
              errors++;
              $display("** Error %s: expected %h actual %h", test_name, want, ifu_o);
            end
        end
      end
      if (ifu_o_valid && !ifu_o_ready) begin
        stalls++;
      end
      // handoff in the ack cycle is still pre-flush, later ones follow the target
      if (flush_ack) begin
        refill_expected(flush.add_op1 + flush.add_op2);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, a test never finished", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // ====================================================================
  // test sequence
  // ====================================================================
  initial begin
    int taken_before;
    void'($urandom(32'hd635));
    reset          = 1'b1;
    pc_rtvec       = RTVEC;
    itcm_cmd_ready = 1'b1;
    flush_req      = 1'b0;
    flush          = '0;
    halt_req       = 1'b0;
    stall_on       = 1'b0;
    build_program();
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    start_test("reset");
    while (!first_cmd_seen) @(posedge clk);
    end_test();

    start_test("sequential");
    run_handoffs(20);
    end_test();

    start_test("prediction");
    taken_before = taken_seen;
    run_handoffs(30);
    assert (taken_seen > taken_before)
      else begin
        errors++;
        $display("prediction: no taken JAL or branch reached the execute side");
      end
    end_test();

    start_test("backpressure");
    stall_on <= 1'b1;
    run_handoffs(40);
    assert (stalls > 0)
      else begin
        errors++;
        $display("backpressure: ifu_o_ready never stalled a valid instruction");
      end
    end_test();

    // first target is straight-line code, second lands back in the loop
    start_test("flush");
    redirect(32'h200, 32'h40);
    run_handoffs(15);
    redirect(32'h0f0, 32'h20);
    run_handoffs(15);
    end_test();

    start_test("halt");
    halt_req <= 1'b1;
    do begin
      @(posedge clk);
    end while (!halt_ack);
    repeat (10) @(posedge clk);
    halt_req <= 1'b0;
    run_handoffs(20);
    end_test();

    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, error_total());
    if (error_total() == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: tests/ifu_properties.sv
/* concurrent checks on the fetch unit ports, bound into every ifu
   instance by the testbench */
`timescale 1ns/1ns

module ifu_properties (
  input logic                   clk,
  input logic                   reset,
  input ifu_types_pkg::pc_t     pc_rtvec,
  input ifu_types_pkg::pc_t     inspect_pc,
  input logic                   itcm_cmd_valid,
  input logic                   itcm_cmd_ready,
  input logic                   itcm_rsp_valid,
  input logic                   itcm_rsp_ready,
  input logic                   ifu_o_valid,
  input logic                   ifu_o_ready,
  input ifu_bus_pkg::ir_stage_t ifu_o,
  input logic                   flush_req,
  input logic                   flush_ack,
  input logic                   halt_req,
  input logic                   halt_ack
);

  // failed assertions so far
  int   failures = 0;
  // command taken by the ITCM, response not yet taken back
  logic outstanding;
  logic cmd_xfer;
  logic rsp_xfer;

  assign cmd_xfer = itcm_cmd_valid && itcm_cmd_ready;
  assign rsp_xfer = itcm_rsp_valid && itcm_rsp_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding <= 1'b0;
    end else if (cmd_xfer) begin
      outstanding <= 1'b1;
    end else if (rsp_xfer) begin
      outstanding <= 1'b0;
    end
  end

  // ====================================================================
  // reset, handoff and back-pressure
  // ====================================================================

  // quiet outputs and pc at the vector after every reset edge
  reset_quiet: assert property (@(posedge clk)
    reset |=> (!ifu_o_valid && !flush_ack && !halt_ack && inspect_pc == pc_rtvec))
    else begin
      failures++;
      $error("outputs not idle or pc off the reset vector after a reset edge");
    end

  // no command toward the ITCM until reset is released
  cmd_quiet_in_reset: assert property (@(posedge clk)
    reset |-> !itcm_cmd_valid)
    else begin
      failures++;
      $error("itcm_cmd_valid high while reset was applied");
    end

  // IR payload frozen while execute stalls
  ir_hold: assert property (@(posedge clk) disable iff (reset)
    (ifu_o_valid && !ifu_o_ready && !flush_ack) |=> (ifu_o_valid && $stable(ifu_o)))
    else begin
      failures++;
      $error("ifu_o changed or dropped while ifu_o_ready was low");
    end

  // accepted word shows up at execute one cycle later
  rsp_to_ir: assert property (@(posedge clk) disable iff (reset)
    (rsp_xfer && !flush_ack) |=> ifu_o_valid)
    else begin
      failures++;
      $error("response accepted but ifu_o_valid did not rise next cycle");
    end

  // next fetch follows at once unless commit steps in
  rsp_to_cmd: assert property (@(posedge clk) disable iff (reset)
    (rsp_xfer && !flush_ack) |=> (itcm_cmd_valid || flush_req || halt_req))
    else begin
      failures++;
      $error("no new command in the cycle after a response");
    end

  // ====================================================================
  // halt
  // ====================================================================
  halt_drained: assert property (@(posedge clk) disable iff (reset)
    halt_ack |-> (!outstanding && !itcm_cmd_valid))
    else begin
      failures++;
      $error("halt_ack high with a fetch outstanding or a command raised");
    end

endmodule

// File: tests/ifu_clock_gen.sv
/* free-running testbench clock for the fetch unit, 4 ns period */
`timescale 1ns/1ns

module ifu_clock_gen (
  output logic clk
);

  // start low so the first rising edge lands at 2 ns
  initial begin
    clk = 1'b0;
  end

  // half period
  always #2 clk = ~clk;

endmodule

// File: verilog/ifu.sv
/* fetch unit top: sequencer, pc counter, mini-decoder, ITCM bridge and
   IR stage wired together between the ITCM and the execute unit */
`timescale 1ns/1ns

module ifu (
  input  logic                      clk,
  input  logic                      reset,
  input  ifu_types_pkg::pc_t        pc_rtvec,
  output ifu_types_pkg::pc_t        inspect_pc,
  output logic                      itcm_cmd_valid,
  input  logic                      itcm_cmd_ready,
  output ifu_types_pkg::itcm_addr_t itcm_cmd_addr,
  input  logic                      itcm_rsp_valid,
  output logic                      itcm_rsp_ready,
  input  ifu_types_pkg::instr_t     itcm_rsp_rdata,
  output logic                      ifu_o_valid,
  input  logic                      ifu_o_ready,
  output ifu_bus_pkg::ir_stage_t    ifu_o,
  input  logic                      flush_req,
  input  ifu_bus_pkg::flush_t       flush,
  output logic                      flush_ack,
  input  logic                      halt_req,
  output logic                      halt_ack
);
  import ifu_types_pkg::*;
  import ifu_bus_pkg::*;

  // request / response between sequencer and bridge
  logic      req_valid;
  logic      req_ready;
  ifu_req_t  req;
  logic      rsp_valid;
  logic      rsp_ready;
  ifu_rsp_t  rsp;

  // sequencer controls
  logic      ir_free;
  logic      pc_advance;
  logic      pc_flush_load;
  logic      ir_load;
  logic      ir_clear;

  // mini-decoder results
  logic      prdt_taken;
  pc_t       prdt_target;
  rfidx_t    rs1idx;
  rfidx_t    rs2idx;
  ir_stage_t ir_next;

  // ==================================================================
  // control and pc
  // ==================================================================
  ifu_fetch_ctrl ifu_fetch_ctrl_inst (
    .clk           (clk),
    .reset         (reset),
    .halt_req      (halt_req),
    .halt_ack      (halt_ack),
    .flush_req     (flush_req),
    .flush_ack     (flush_ack),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .ir_free       (ir_free),
    .pc_advance    (pc_advance),
    .pc_flush_load (pc_flush_load),
    .ir_load       (ir_load),
    .ir_clear      (ir_clear)
  );

  ifu_pc_gen ifu_pc_gen_inst (
    .clk           (clk),
    .reset         (reset),
    .pc_rtvec      (pc_rtvec),
    .pc_advance    (pc_advance),
    .pc_flush_load (pc_flush_load),
    .prdt_taken    (prdt_taken),
    .prdt_target   (prdt_target),
    .flush         (flush),
    .req           (req),
    .inspect_pc    (inspect_pc)
  );

  // pc is still the request pc while the fetch is outstanding
  ifu_minidec ifu_minidec_inst (
    .instr       (rsp.instr),
    .pc          (req.pc),
    .rs1idx      (rs1idx),
    .rs2idx      (rs2idx),
    .prdt_taken  (prdt_taken),
    .prdt_target (prdt_target)
  );

  // ==================================================================
  // ITCM bridge and IR stage
  // ==================================================================
  ifu_ifu2itcm ifu_ifu2itcm_inst (
    .clk            (clk),
    .reset          (reset),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req            (req),
    .rsp_valid      (rsp_valid),
    .rsp_ready      (rsp_ready),
    .rsp            (rsp),
    .itcm_cmd_valid (itcm_cmd_valid),
    .itcm_cmd_ready (itcm_cmd_ready),
    .itcm_cmd_addr  (itcm_cmd_addr),
    .itcm_rsp_valid (itcm_rsp_valid),
    .itcm_rsp_ready (itcm_rsp_ready),
    .itcm_rsp_rdata (itcm_rsp_rdata)
  );

  assign ir_next.ir         = rsp.instr;
  assign ir_next.pc         = req.pc;
  assign ir_next.rs1idx     = rs1idx;
  assign ir_next.rs2idx     = rs2idx;
  assign ir_next.prdt_taken = prdt_taken;

  ifu_ir_stage ifu_ir_stage_inst (
    .clk         (clk),
    .reset       (reset),
    .ir_load     (ir_load),
    .ir_clear    (ir_clear),
    .ir_next     (ir_next),
    .ir_free     (ir_free),
    .ifu_o_valid (ifu_o_valid),
    .ifu_o_ready (ifu_o_ready),
    .ifu_o       (ifu_o)
  );

endmodule

// File: verilog/ifu_ir_stage.sv
/* instruction register toward the execute unit, loaded from each
   accepted fetch response and handed off through valid/ready */
`timescale 1ns/1ns

module ifu_ir_stage (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   ir_load,
  input  logic                   ir_clear,
  input  ifu_bus_pkg::ir_stage_t ir_next,
  output logic                   ir_free,
  output logic                   ifu_o_valid,
  input  logic                   ifu_o_ready,
  output ifu_bus_pkg::ir_stage_t ifu_o
);
  import ifu_bus_pkg::*;

  logic      valid_q;
  ir_stage_t ir_q;

  // empty, or execute takes the current one this cycle
  assign ir_free = !valid_q || ifu_o_ready;

  // ==================================================================
  // valid bit
  // ==================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (ir_clear) begin
      // flush kills whatever is waiting
      valid_q <= 1'b0;
    end else if (ir_load) begin
      valid_q <= 1'b1;
    end else if (ifu_o_ready) begin
      valid_q <= 1'b0;
    end
  end

  // payload only changes on a load, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (ir_load) begin
      ir_q <= ir_next;
    end
  end

  assign ifu_o_valid = valid_q;
  assign ifu_o       = ir_q;

endmodule

// File: verilog/ifu_ifu2itcm.sv
/* bridge from the fetch request/response pair to the ITCM command and
   response channels, one fetch in flight at most */
`timescale 1ns/1ns
`include "ifu_consts.svh"

module ifu_ifu2itcm (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_valid,
  output logic                      req_ready,
  input  ifu_bus_pkg::ifu_req_t     req,
  output logic                      rsp_valid,
  input  logic                      rsp_ready,
  output ifu_bus_pkg::ifu_rsp_t     rsp,
  output logic                      itcm_cmd_valid,
  input  logic                      itcm_cmd_ready,
  output ifu_types_pkg::itcm_addr_t itcm_cmd_addr,
  input  logic                      itcm_rsp_valid,
  output logic                      itcm_rsp_ready,
  input  ifu_types_pkg::instr_t     itcm_rsp_rdata
);
  import ifu_types_pkg::*;

  // command accepted, response not yet taken
  logic       pend_q;
  // word address of the last command sent
  itcm_addr_t last_addr_q;
  itcm_addr_t seq_addr;
  logic       cmd_xfer;
  logic       rsp_xfer;

  // ==================================================================
  // command channel
  // ==================================================================

  // sequential fetch just bumps the last word address
  assign seq_addr      = last_addr_q + itcm_addr_t'(1);
  assign itcm_cmd_addr = req.seq ? seq_addr : req.pc[`IFU_ITCM_ADDR_WIDTH+1:2];

  // blocked while a response is pending
  assign itcm_cmd_valid = req_valid && !pend_q;
  assign req_ready      = itcm_cmd_ready && !pend_q;

  assign cmd_xfer = itcm_cmd_valid && itcm_cmd_ready;
  assign rsp_xfer = itcm_rsp_valid && itcm_rsp_ready;

  // ==================================================================
  // response channel
  // ==================================================================
  assign rsp_valid      = itcm_rsp_valid;
  assign rsp.instr      = itcm_rsp_rdata;
  assign itcm_rsp_ready = rsp_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      pend_q <= 1'b0;
    end else if (cmd_xfer) begin
      pend_q <= 1'b1;
    end else if (rsp_xfer) begin
      pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_xfer) begin
      last_addr_q <= itcm_cmd_addr;
    end
  end

endmodule

// File: verilog/ifu_minidec.sv
/* mini-decoder on the fetched word: pulls out rs1/rs2 and predicts
   JAL and conditional branches with a static backward-taken rule */
`timescale 1ns/1ns
`include "ifu_consts.svh"

module ifu_minidec (
  input  ifu_types_pkg::instr_t instr,
  input  ifu_types_pkg::pc_t    pc,
  output ifu_types_pkg::rfidx_t rs1idx,
  output ifu_types_pkg::rfidx_t rs2idx,
  output logic                  prdt_taken,
  output ifu_types_pkg::pc_t    prdt_target
);
  import ifu_types_pkg::*;

  logic       is_jal;
  logic       is_bxx;
  logic [6:0] opcode;
  pc_t        jal_imm;
  pc_t        bxx_imm;
  pc_t        offset;

  // ==================================================================
  // decode
  // ==================================================================
  assign opcode = instr[6:0];
  assign is_jal = (opcode == `IFU_OPC_JAL);
  assign is_bxx = (opcode == `IFU_OPC_BRANCH);

  // register fields sit at fixed spots in every format
  assign rs1idx = instr[19:15];
  assign rs2idx = instr[24:20];

  // J-type immediate, bit 0 always zero
  assign jal_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // B-type immediate
  assign bxx_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

  // ==================================================================
  // prediction
  // ==================================================================

  // JAL always, branch only on a negative offset (loops)
  assign prdt_taken = is_jal || (is_bxx && instr[31]);

  assign offset      = is_jal ? jal_imm : bxx_imm;
  assign prdt_target = pc + offset;

endmodule

// File: verilog/ifu_pc_gen.sv
/* program counter: starts at the reset vector, steps by 4, follows the
   mini-decoder prediction, or jumps to the flush target */
`timescale 1ns/1ns

module ifu_pc_gen (
  input  logic                 clk,
  input  logic                 reset,
  input  ifu_types_pkg::pc_t   pc_rtvec,
  input  logic                 pc_advance,
  input  logic                 pc_flush_load,
  input  logic                 prdt_taken,
  input  ifu_types_pkg::pc_t   prdt_target,
  input  ifu_bus_pkg::flush_t  flush,
  output ifu_bus_pkg::ifu_req_t req,
  output ifu_types_pkg::pc_t   inspect_pc
);
  import ifu_types_pkg::*;

  pc_t  pc_q;
  pc_t  pc_incr;
  pc_t  flush_target;
  logic seq_q;

  assign pc_incr      = pc_q + pc_t'(4);
  assign flush_target = flush.add_op1 + flush.add_op2;

  // ==================================================================
  // pc register
  // ==================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q  <= pc_rtvec;
      seq_q <= 1'b0;
    end else if (pc_flush_load) begin
      // redirect wins over any advance
      pc_q  <= flush_target;
      seq_q <= 1'b0;
    end else if (pc_advance) begin
      if (prdt_taken) begin
        pc_q  <= prdt_target;
        seq_q <= 1'b0;
      end else begin
        pc_q  <= pc_incr;
        seq_q <= 1'b1;
      end
    end
  end

  // request always points at the current pc
  assign req.pc     = pc_q;
  assign req.seq    = seq_q;
  assign inspect_pc = pc_q;

endmodule

// File: verilog/ifu_fetch_ctrl.sv
/* fetch sequencer: issues one request at a time, steers the pc counter
   and IR stage, and answers flush and halt requests from commit */
`timescale 1ns/1ns

module ifu_fetch_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic halt_req,
  output logic halt_ack,
  input  logic flush_req,
  output logic flush_ack,
  output logic req_valid,
  input  logic req_ready,
  input  logic rsp_valid,
  output logic rsp_ready,
  input  logic ir_free,
  output logic pc_advance,
  output logic pc_flush_load,
  output logic ir_load,
  output logic ir_clear
);
  import ifu_types_pkg::*;

  fetch_state_t state_q;
  fetch_state_t state_d;
  // request raised last cycle but not taken, must stay up
  logic         req_hold_q;

  // ==================================================================
  // next state and per-cycle controls
  // ==================================================================
  always_comb begin
    state_d       = state_q;
    req_valid     = 1'b0;
    rsp_ready     = 1'b0;
    flush_ack     = 1'b0;
    pc_advance    = 1'b0;
    pc_flush_load = 1'b0;
    ir_load       = 1'b0;
    ir_clear      = 1'b0;
    case (state_q)
      FETCH_REQ: begin
        if (req_hold_q) begin
          // committed to this request, flush and halt wait for it
          req_valid = 1'b1;
          if (req_ready) begin
            state_d = FETCH_WAIT;
          end
        end else if (flush_req) begin
          // nothing outstanding, redirect right away
          flush_ack     = 1'b1;
          pc_flush_load = 1'b1;
          ir_clear      = 1'b1;
        end else if (halt_req) begin
          state_d = FETCH_HALT;
        end else if (!reset) begin
          // first command only once reset is released
          req_valid = 1'b1;
          if (req_ready) begin
            state_d = FETCH_WAIT;
          end
        end
      end
      FETCH_WAIT: begin
        if (flush_req) begin
          // leave the response parked in the ITCM, drop it next state
          state_d = FETCH_FLUSH;
        end else begin
          rsp_ready = ir_free;
          if (rsp_valid && ir_free) begin
            ir_load    = 1'b1;
            pc_advance = 1'b1;
            state_d    = FETCH_REQ;
          end
        end
      end
      FETCH_FLUSH: begin
        // take and discard the stale word
        rsp_ready = 1'b1;
        if (rsp_valid) begin
          flush_ack     = 1'b1;
          pc_flush_load = 1'b1;
          ir_clear      = 1'b1;
          state_d       = FETCH_REQ;
        end
      end
      FETCH_HALT: begin
        // a flush can still land while stopped
        if (flush_req) begin
          flush_ack     = 1'b1;
          pc_flush_load = 1'b1;
          ir_clear      = 1'b1;
        end
        if (!halt_req) begin
          state_d = FETCH_REQ;
        end
      end
      default: begin
        state_d = FETCH_REQ;
      end
    endcase
  end

  // ack only while commit still asks for it
  assign halt_ack = (state_q == FETCH_HALT) && halt_req;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q    <= FETCH_REQ;
      req_hold_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      req_hold_q <= req_valid && !req_ready;
    end
  end

endmodule

// File: verilog/ifu_bus_pkg.sv
/* bundles passed between the fetch blocks: request, response, IR stage
   contents toward execute, and the flush operands from commit */
package ifu_bus_pkg;

  // ==================================================================
  // fetch request and response
  // ==================================================================

  // seq set when pc is the previous fetch address plus 4
  typedef struct packed {
    ifu_types_pkg::pc_t pc;
    logic               seq;
  } ifu_req_t;

  // returned instruction word
  typedef struct packed {
    ifu_types_pkg::instr_t instr;
  } ifu_rsp_t;

  // ==================================================================
  // execute side and commit side
  // ==================================================================

  // what the execute unit gets with ifu_o_valid
  typedef struct packed {
    ifu_types_pkg::instr_t ir;
    ifu_types_pkg::pc_t    pc;
    ifu_types_pkg::rfidx_t rs1idx;
    ifu_types_pkg::rfidx_t rs2idx;
    logic                  prdt_taken;
  } ir_stage_t;

  // redirect target is add_op1 + add_op2
  typedef struct packed {
    ifu_types_pkg::pc_t add_op1;
    ifu_types_pkg::pc_t add_op2;
  } flush_t;

endpackage

// File: verilog/ifu_types_pkg.sv
/* scalar types of the fetch unit: pc, instruction, register index,
   ITCM word address and the fetch controller states */
`include "ifu_consts.svh"

package ifu_types_pkg;

  // byte address of an instruction
  typedef logic [`IFU_PC_SIZE-1:0] pc_t;

  // raw 32-bit instruction word
  typedef logic [`IFU_INSTR_SIZE-1:0] instr_t;

  // x0..x31
  typedef logic [`IFU_RFIDX_WIDTH-1:0] rfidx_t;

  // word index into the ITCM
  typedef logic [`IFU_ITCM_ADDR_WIDTH-1:0] itcm_addr_t;

  // fetch sequencing
  //   FETCH_REQ   idle or presenting a request
  //   FETCH_WAIT  one fetch outstanding
  //   FETCH_FLUSH outstanding fetch to be dropped
  //   FETCH_HALT  stopped, nothing outstanding
  typedef enum logic [1:0] {
    FETCH_REQ,
    FETCH_WAIT,
    FETCH_FLUSH,
    FETCH_HALT
  } fetch_state_t;

endpackage

// File: include/ifu_consts.svh
/* widths and opcode constants for the fetch unit and its testbench,
   included by every file that sizes a bus or matches an opcode */
`ifndef IFU_CONSTS_SVH
`define IFU_CONSTS_SVH

// ====================================================================
// datapath widths
// ====================================================================
`define IFU_PC_SIZE          32
`define IFU_INSTR_SIZE       32
`define IFU_RFIDX_WIDTH      5
// word address into the ITCM, pc bits 15:2
`define IFU_ITCM_ADDR_WIDTH  14

// ====================================================================
// opcodes seen by the mini-decoder
// ====================================================================
`define IFU_OPC_JAL          7'b1101111
`define IFU_OPC_BRANCH       7'b1100011

`endif
